// ==== soc_settings.svh ====
// SoC settings: bus widths, CSR register map, reset hold counts and board id
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ------------------------------
// Widths
// ------------------------------
`define CSR_ADDR_W 14
`define CSR_BANK_W 4
`define CSR_DATA_W 32
`define GPIO_IN_W 3
`define GPIO_OUT_W 2

// ------------------------------
// CSR map
// ------------------------------
// Bank numbers sit in the top address bits
`define BANK_SYSCTL 4'd1
`define BANK_IRQ 4'd2

// Register indices, 10 bits below the bank field
`define SYSCTL_REG_GPIO_IN 10'd0
`define SYSCTL_REG_GPIO_OUT 10'd1
`define SYSCTL_REG_TIMER_CTRL 10'd2
`define SYSCTL_REG_TIMER_CMP 10'd3
`define SYSCTL_REG_TIMER_CNT 10'd4
`define SYSCTL_REG_SYSID 10'd5
`define SYSCTL_REG_HARD_RESET 10'd6

`define IRQ_REG_PENDING 10'd0
`define IRQ_REG_MASK 10'd1

// Pending bit positions
`define IRQ_GPIO_BIT 2
`define IRQ_TIMER_BIT 3

// ASCII "SYSC"
`define SYSTEM_ID 32'h53595343

// Reset hold lengths in sys_clk cycles, kept short for simulation
`define RST_HOLD_CYCLES 64
`define FLASH_RST_CYCLES 16

`endif

// ==== soc_pkg.sv ====
// SoC package: CSR address word with raw and bank/index views
`include "soc_settings.svh"

package soc_pkg;

	// ------------------------------
	// CSR address decoding
	// ------------------------------
	typedef struct packed {
		logic [`CSR_BANK_W-1:0] bank;
		logic [`CSR_ADDR_W-`CSR_BANK_W-1:0] idx;
	} csr_fields_t;

	// Same 14 bits, latched raw by the bus and decoded by field in the slaves
	typedef union packed {
		logic [`CSR_ADDR_W-1:0] raw;
		csr_fields_t f;
	} csr_addr_t;

endpackage

// ==== reset_gen.sv ====
// Reset generator: merges reset triggers and releases flash reset before peripheral reset
`timescale 1ns/10ps
`include "soc_settings.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic [`GPIO_IN_W-1:0] btn_i,
	input  logic hard_reset_req_i,
	output logic sys_rst_o,
	output logic periph_rst_n_o,
	output logic flash_rst_n_o
);

	localparam int HOLD_W = $clog2(`RST_HOLD_CYCLES + 1);
	localparam int FLASH_W = $clog2(`FLASH_RST_CYCLES + 1);

	logic btn_all_q;
	logic trigger;
	logic [HOLD_W-1:0] hold_cnt;
	logic [FLASH_W-1:0] flash_cnt;

	// All three buttons together act as a reset button
	always_ff @(posedge sys_clk) begin
		btn_all_q <= &btn_i;
	end

	assign trigger = trigger_reset | btn_all_q | hard_reset_req_i;

	// ------------------------------
	// System hold, counts down
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (trigger)
			hold_cnt <= HOLD_W'(`RST_HOLD_CYCLES);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
		sys_rst_o <= trigger | (hold_cnt != '0);
		// Peripheral pin trails the internal reset by one cycle
		periph_rst_n_o <= ~sys_rst_o;
	end

	// ------------------------------
	// Flash hold, counts up
	// ------------------------------
	// Shorter than the system hold so flash is out of reset first
	always_ff @(posedge sys_clk) begin
		if (trigger)
			flash_cnt <= '0;
		else if (flash_cnt != FLASH_W'(`FLASH_RST_CYCLES))
			flash_cnt <= flash_cnt + 1'b1;
		flash_rst_n_o <= (flash_cnt == FLASH_W'(`FLASH_RST_CYCLES));
	end

endmodule

// ==== csr_bus.sv ====
// CSR bus front: registers external accesses, broadcasts them and merges slave read data
`timescale 1ns/10ps
`include "soc_settings.svh"

module csr_bus (
	input  logic sys_clk,
	input  logic sys_rst_i,

	// External access, single-cycle strobe
	input  logic csr_stb_i,
	input  logic csr_we_i,
	input  logic [`CSR_ADDR_W-1:0] csr_adr_i,
	input  logic [`CSR_DATA_W-1:0] csr_dat_i,

	// Broadcast to slaves
	output soc_pkg::csr_addr_t csr_a_o,
	output logic csr_sel_o,
	output logic csr_we_o,
	output logic [`CSR_DATA_W-1:0] csr_dw_o,

	// Slave read words
	input  logic [`CSR_DATA_W-1:0] sysctl_dr_i,
	input  logic [`CSR_DATA_W-1:0] irq_dr_i,

	// Read return
	output logic [`CSR_DATA_W-1:0] csr_rdata_o,
	output logic csr_rvalid_o
);

	logic rd_s1;
	logic rd_s2;

	// ------------------------------
	// Strobe and read tracking
	// ------------------------------
	// Stage 1 matches the broadcast, stage 2 the slave read register
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_sel_o <= 1'b0;
			rd_s1 <= 1'b0;
			rd_s2 <= 1'b0;
			csr_rvalid_o <= 1'b0;
		end else begin
			csr_sel_o <= csr_stb_i;
			rd_s1 <= csr_stb_i & ~csr_we_i;
			rd_s2 <= rd_s1;
			csr_rvalid_o <= rd_s2;
		end
	end

	// ------------------------------
	// Access payload
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		csr_a_o.raw <= csr_adr_i;
		csr_we_o <= csr_we_i;
		csr_dw_o <= csr_dat_i;
	end

	// Unaddressed slaves drive zero, so the OR acts as the read mux
	always_ff @(posedge sys_clk) begin
		if (rd_s2)
			csr_rdata_o <= sysctl_dr_i | irq_dr_i;
	end

endmodule

// ==== sysctl.sv ====
// System controller: GPIO, one compare timer, system id and hard reset request
`timescale 1ns/10ps
`include "soc_settings.svh"

module sysctl (
	input  logic sys_clk,
	input  logic sys_rst_i,

	// CSR slave side
	input  soc_pkg::csr_addr_t csr_a_i,
	input  logic csr_sel_i,
	input  logic csr_we_i,
	input  logic [`CSR_DATA_W-1:0] csr_dw_i,
	output logic [`CSR_DATA_W-1:0] csr_dr_o,

	// GPIO
	input  logic [`GPIO_IN_W-1:0] btn_i,
	output logic [`GPIO_OUT_W-1:0] led_o,

	// Events
	output logic gpio_irq_o,
	output logic timer_irq_o,
	output logic hard_reset_req_o
);

	localparam int DATA_W = `CSR_DATA_W;

	logic bank_hit;
	logic wr;
	logic [`GPIO_IN_W-1:0] btn_s1;
	logic [`GPIO_IN_W-1:0] btn_s2;
	logic [`GPIO_IN_W-1:0] btn_prev;
	logic timer_en;
	logic [DATA_W-1:0] timer_cmp;
	logic [DATA_W-1:0] timer_cnt;
	logic [DATA_W-1:0] rd_word;

	assign bank_hit = csr_sel_i & (csr_a_i.f.bank == `BANK_SYSCTL);
	assign wr = bank_hit & csr_we_i;

	// ------------------------------
	// Button synchronizer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		btn_s1 <= btn_i;
		btn_s2 <= btn_s1;
		btn_prev <= btn_s2;
	end

	// ------------------------------
	// Control registers and timer
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led_o <= '0;
			gpio_irq_o <= 1'b0;
			timer_irq_o <= 1'b0;
			timer_en <= 1'b0;
			timer_cnt <= '0;
			hard_reset_req_o <= 1'b0;
		end else begin
			// Any change on the synchronized buttons
			gpio_irq_o <= (btn_s2 != btn_prev);
			timer_irq_o <= 1'b0;
			hard_reset_req_o <= wr & (csr_a_i.f.idx == `SYSCTL_REG_HARD_RESET);
			if (wr & (csr_a_i.f.idx == `SYSCTL_REG_GPIO_OUT))
				led_o <= csr_dw_i[`GPIO_OUT_W-1:0];
			if (wr & (csr_a_i.f.idx == `SYSCTL_REG_TIMER_CTRL)) begin
				timer_en <= csr_dw_i[0];
				timer_cnt <= '0;
			end else if (wr & (csr_a_i.f.idx == `SYSCTL_REG_TIMER_CNT)) begin
				timer_cnt <= csr_dw_i;
			end else if (timer_en) begin
				// One-shot: stop on match
				if (timer_cnt == timer_cmp) begin
					timer_en <= 1'b0;
					timer_irq_o <= 1'b1;
				end else begin
					timer_cnt <= timer_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr & (csr_a_i.f.idx == `SYSCTL_REG_TIMER_CMP))
			timer_cmp <= csr_dw_i;
	end

	// ------------------------------
	// Read side
	// ------------------------------
	always_comb begin
		case (csr_a_i.f.idx)
			`SYSCTL_REG_GPIO_IN:    rd_word = DATA_W'(btn_s2);
			`SYSCTL_REG_GPIO_OUT:   rd_word = DATA_W'(led_o);
			`SYSCTL_REG_TIMER_CTRL: rd_word = DATA_W'(timer_en);
			`SYSCTL_REG_TIMER_CMP:  rd_word = timer_cmp;
			`SYSCTL_REG_TIMER_CNT:  rd_word = timer_cnt;
			`SYSCTL_REG_SYSID:      rd_word = `SYSTEM_ID;
			default:                rd_word = '0;
		endcase
	end

	// Zero when another bank is addressed
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= bank_hit ? rd_word : '0;
	end

endmodule

// ==== irq_collect.sv ====
// Interrupt collector: pending and mask registers driving the CPU interrupt line
`timescale 1ns/10ps
`include "soc_settings.svh"

module irq_collect (
	input  logic sys_clk,
	input  logic sys_rst_i,

	// CSR slave side
	input  soc_pkg::csr_addr_t csr_a_i,
	input  logic csr_sel_i,
	input  logic csr_we_i,
	input  logic [`CSR_DATA_W-1:0] csr_dw_i,
	output logic [`CSR_DATA_W-1:0] csr_dr_o,

	// Event pulses
	input  logic gpio_irq_i,
	input  logic timer_irq_i,
	output logic irq_o
);

	localparam int DATA_W = `CSR_DATA_W;
	// Wide enough for the highest used pending bit
	localparam int IRQ_W = ((`IRQ_GPIO_BIT > `IRQ_TIMER_BIT) ?
		`IRQ_GPIO_BIT : `IRQ_TIMER_BIT) + 1;

	logic bank_hit;
	logic wr;
	logic [IRQ_W-1:0] pending;
	logic [IRQ_W-1:0] pending_nxt;
	logic [IRQ_W-1:0] mask;

	assign bank_hit = csr_sel_i & (csr_a_i.f.bank == `BANK_IRQ);
	assign wr = bank_hit & csr_we_i;

	// Write 1 to clear, a new event in the same cycle wins
	always_comb begin
		pending_nxt = pending;
		if (wr & (csr_a_i.f.idx == `IRQ_REG_PENDING))
			pending_nxt = pending & ~csr_dw_i[IRQ_W-1:0];
		if (gpio_irq_i)
			pending_nxt[`IRQ_GPIO_BIT] = 1'b1;
		if (timer_irq_i)
			pending_nxt[`IRQ_TIMER_BIT] = 1'b1;
	end

	// ------------------------------
	// State and interrupt line
	// ------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			pending <= '0;
			mask <= '0;
			irq_o <= 1'b0;
		end else begin
			pending <= pending_nxt;
			if (wr & (csr_a_i.f.idx == `IRQ_REG_MASK))
				mask <= csr_dw_i[IRQ_W-1:0];
			irq_o <= |(pending & mask);
		end
	end

	// Read side, zero outside this bank
	always_ff @(posedge sys_clk) begin
		if (!bank_hit)
			csr_dr_o <= '0;
		else if (csr_a_i.f.idx == `IRQ_REG_PENDING)
			csr_dr_o <= DATA_W'(pending);
		else if (csr_a_i.f.idx == `IRQ_REG_MASK)
			csr_dr_o <= DATA_W'(mask);
		else
			csr_dr_o <= '0;
	end

endmodule

// ==== soc_top.sv ====
// SoC system-control top: reset generator, CSR bus, system controller and interrupts
`timescale 1ns/10ps
`include "soc_settings.svh"

module soc_top (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic [`GPIO_IN_W-1:0] btn_i,

	// External CSR access
	input  logic csr_stb_i,
	input  logic csr_we_i,
	input  logic [`CSR_ADDR_W-1:0] csr_adr_i,
	input  logic [`CSR_DATA_W-1:0] csr_dat_i,
	output logic [`CSR_DATA_W-1:0] csr_rdata_o,
	output logic csr_rvalid_o,

	output logic [`GPIO_OUT_W-1:0] led_o,
	output logic irq_o,
	output logic periph_rst_n_o,
	output logic flash_rst_n_o
);

	logic sys_rst;
	logic hard_reset_req;
	soc_pkg::csr_addr_t csr_a;
	logic csr_sel;
	logic csr_we;
	logic [`CSR_DATA_W-1:0] csr_dw;
	logic [`CSR_DATA_W-1:0] csr_dr_sysctl;
	logic [`CSR_DATA_W-1:0] csr_dr_irq;
	logic gpio_irq;
	logic timer_irq;

	// ------------------------------
	// Input side
	// ------------------------------
	reset_gen u_reset_gen (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.hard_reset_req_i(hard_reset_req),
		.sys_rst_o(sys_rst),
		.periph_rst_n_o(periph_rst_n_o),
		.flash_rst_n_o(flash_rst_n_o)
	);

	csr_bus u_csr_bus (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_stb_i(csr_stb_i),
		.csr_we_i(csr_we_i),
		.csr_adr_i(csr_adr_i),
		.csr_dat_i(csr_dat_i),
		.csr_a_o(csr_a),
		.csr_sel_o(csr_sel),
		.csr_we_o(csr_we),
		.csr_dw_o(csr_dw),
		.sysctl_dr_i(csr_dr_sysctl),
		.irq_dr_i(csr_dr_irq),
		.csr_rdata_o(csr_rdata_o),
		.csr_rvalid_o(csr_rvalid_o)
	);

	// ------------------------------
	// System controller
	// ------------------------------
	sysctl u_sysctl (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i(csr_a),
		.csr_sel_i(csr_sel),
		.csr_we_i(csr_we),
		.csr_dw_i(csr_dw),
		.csr_dr_o(csr_dr_sysctl),
		.btn_i(btn_i),
		.led_o(led_o),
		.gpio_irq_o(gpio_irq),
		.timer_irq_o(timer_irq),
		.hard_reset_req_o(hard_reset_req)
	);

	// ------------------------------
	// Output side
	// ------------------------------
	irq_collect u_irq_collect (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr_a_i(csr_a),
		.csr_sel_i(csr_sel),
		.csr_we_i(csr_we),
		.csr_dw_i(csr_dw),
		.csr_dr_o(csr_dr_irq),
		.gpio_irq_i(gpio_irq),
		.timer_irq_i(timer_irq),
		.irq_o(irq_o)
	);

endmodule

// ==== soc_asserts.sv ====
// SoC protocol checks: read latency, reset release order and LED state in reset
`timescale 1ns/10ps
`include "soc_settings.svh"

module soc_asserts (
	input logic sys_clk,
	input logic trigger_reset,
	input logic sys_rst_i,
	input logic stb_i,
	input logic we_i,
	input logic rvalid_i,
	input logic periph_rst_n_i,
	input logic flash_rst_n_i,
	input logic [`GPIO_OUT_W-1:0] led_i
);

	logic rd_strobe;

	assign rd_strobe = stb_i & ~we_i;

	// Valid is set on the second edge after the strobe edge, so it is sampled one edge later
	rvalid_latency: assert property (@(posedge sys_clk) disable iff (trigger_reset || sys_rst_i)
		rvalid_i == $past(rd_strobe, 3))
		else $error("read valid does not trail a read strobe by two cycles");

	flash_first: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		periph_rst_n_i |-> flash_rst_n_i)
		else $error("peripheral reset released while flash is still in reset");

	led_in_reset: assert property (@(posedge sys_clk) disable iff (trigger_reset)
		!periph_rst_n_i |-> (led_i == '0))
		else $error("LEDs are lit during peripheral reset");

endmodule

bind soc_top soc_asserts u_asserts (
	.sys_clk(sys_clk),
	.trigger_reset(trigger_reset),
	.sys_rst_i(sys_rst),
	.stb_i(csr_stb_i),
	.we_i(csr_we_i),
	.rvalid_i(csr_rvalid_o),
	.periph_rst_n_i(periph_rst_n_o),
	.flash_rst_n_i(flash_rst_n_o),
	.led_i(led_o)
);

// ==== tb_soc.sv ====
// Testbench for the SoC system-control block that replays CSR accesses from a case file
`timescale 1ns/10ps
`include "soc_settings.svh"

module tb_soc;

	localparam int MAX_CASES = 64;
	localparam int VALID_WAIT = 8;
	localparam int POLL_LIMIT = 200;

	// Case opcodes from the first column of the case file
	localparam logic [31:0] OP_END = 32'h00;
	localparam logic [31:0] OP_WRITE = 32'h01;
	localparam logic [31:0] OP_READ = 32'h02;
	localparam logic [31:0] OP_POLL = 32'h03;
	localparam logic [31:0] OP_BUTTONS = 32'h04;
	localparam logic [31:0] OP_WAIT_RESET = 32'h05;
	localparam logic [31:0] OP_IRQ = 32'h06;
	localparam logic [31:0] OP_WRITE_RAND = 32'h11;
	localparam logic [31:0] OP_READ_RAND = 32'h12;

	localparam logic [`CSR_ADDR_W-1:0] LED_ADR = {`BANK_SYSCTL, `SYSCTL_REG_GPIO_OUT};

	logic sys_clk;
	logic trigger_reset;
	logic [`GPIO_IN_W-1:0] btn_i;
	logic csr_stb_i;
	logic csr_we_i;
	logic [`CSR_ADDR_W-1:0] csr_adr_i;
	logic [`CSR_DATA_W-1:0] csr_dat_i;
	logic [`CSR_DATA_W-1:0] csr_rdata_o;
	logic csr_rvalid_o;
	logic [`GPIO_OUT_W-1:0] led_o;
	logic irq_o;
	logic periph_rst_n_o;
	logic flash_rst_n_o;

	logic [31:0] cases [0:4*MAX_CASES-1];
	int num_cases;
	int value_errs;
	int proto_errs;
	int cycles;
	int cycle_limit;
	logic [31:0] rng_state;
	logic [31:0] last_rand;

	soc_top uut (
		.sys_clk(sys_clk),
		.trigger_reset(trigger_reset),
		.btn_i(btn_i),
		.csr_stb_i(csr_stb_i),
		.csr_we_i(csr_we_i),
		.csr_adr_i(csr_adr_i),
		.csr_dat_i(csr_dat_i),
		.csr_rdata_o(csr_rdata_o),
		.csr_rvalid_o(csr_rvalid_o),
		.led_o(led_o),
		.irq_o(irq_o),
		.periph_rst_n_o(periph_rst_n_o),
		.flash_rst_n_o(flash_rst_n_o)
	);

	initial sys_clk = 1'b0;
	always #10 sys_clk = ~sys_clk;

	// ------------------------------
	// Watchdog
	// ------------------------------
	always @(posedge sys_clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the case list did not complete", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic string op_name(input logic [31:0] op);
		case (op)
			OP_WRITE: return "write";
			OP_READ: return "read";
			OP_POLL: return "poll";
			OP_BUTTONS: return "buttons";
			OP_WAIT_RESET: return "wait-reset";
			OP_IRQ: return "irq-level";
			OP_WRITE_RAND: return "write-random";
			OP_READ_RAND: return "read-random";
			default: return "unknown";
		endcase
	endfunction

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAIL %s expected %h got %h", name, exp, got);
			value_errs++;
		end
	endtask

	task automatic csr_access(input logic we, input logic [31:0] adr, input logic [31:0] dat);
		csr_stb_i = 1'b1;
		csr_we_i = we;
		csr_adr_i = adr[`CSR_ADDR_W-1:0];
		csr_dat_i = dat;
		next_cycle();
		csr_stb_i = 1'b0;
		csr_we_i = 1'b0;
	endtask

	task automatic csr_read(input logic [31:0] adr, output logic [31:0] data, output bit ok);
		int n;
		csr_access(1'b0, adr, 32'h0);
		for (n = 0; n < VALID_WAIT && !csr_rvalid_o; n++)
			next_cycle();
		ok = csr_rvalid_o;
		data = csr_rdata_o;
	endtask

	task automatic poll_until(input string name, input logic [31:0] adr,
			input logic [31:0] mask, input logic [31:0] exp);
		int tries;
		logic [31:0] got;
		bit ok;
		bit hit;
		hit = 1'b0;
		ok = 1'b1;
		got = '0;
		for (tries = 0; tries < POLL_LIMIT && !hit && ok; tries++) begin
			csr_read(adr, got, ok);
			hit = ok && ((got & mask) == exp);
		end
		assert (ok) else begin
			$display("No read valid pulse while polling in %s", name);
			proto_errs++;
		end
		assert (hit || !ok) else begin
			$display("Polling in %s never matched, last word was %h", name, got);
			proto_errs++;
		end
	endtask

	// Expects the peripheral reset to drop and then be released
	task automatic wait_reset(input string name);
		int n;
		for (n = 0; n < 20 && periph_rst_n_o; n++)
			next_cycle();
		assert (!periph_rst_n_o) else begin
			$display("Peripheral reset was never asserted in %s", name);
			proto_errs++;
		end
		check_value({name, " led"}, 32'h0, 32'(led_o));
		for (n = 0; n < `RST_HOLD_CYCLES + 20 && !periph_rst_n_o; n++)
			next_cycle();
		assert (periph_rst_n_o) else begin
			$display("Peripheral reset was never released in %s", name);
			proto_errs++;
		end
	endtask

	// Edge 0 is the first edge that samples trigger_reset low
	task automatic check_reset_release();
		int idx;
		int flash_at;
		int periph_at;
		flash_at = -1;
		periph_at = -1;
		for (idx = 0; idx <= `RST_HOLD_CYCLES + 4; idx++) begin
			next_cycle();
			if (flash_at < 0 && flash_rst_n_o === 1'b1)
				flash_at = idx;
			if (periph_at < 0 && periph_rst_n_o === 1'b1)
				periph_at = idx;
		end
		check_value("reset release flash", `FLASH_RST_CYCLES, flash_at);
		check_value("reset release periph", `RST_HOLD_CYCLES + 1, periph_at);
	endtask

	task automatic run_case(input int n);
		logic [31:0] op;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [31:0] exp;
		logic [31:0] got;
		bit ok;
		string name;
		op = cases[4*n];
		adr = cases[4*n+1];
		dat = cases[4*n+2];
		exp = cases[4*n+3];
		name = $sformatf("case %0d %s %h", n, op_name(op), adr[`CSR_ADDR_W-1:0]);
		case (op)
			OP_WRITE: csr_access(1'b1, adr, dat);
			OP_WRITE_RAND: begin
				rng_state = xorshift(rng_state);
				last_rand = rng_state;
				csr_access(1'b1, adr, last_rand);
			end
			OP_READ, OP_READ_RAND: begin
				if (op == OP_READ_RAND)
					exp = last_rand;
				csr_read(adr, got, ok);
				assert (ok) else begin
					$display("No read valid pulse for %s", name);
					proto_errs++;
				end
				if (ok)
					check_value(name, exp, got);
				// LED pins follow the register
				if (ok && adr[`CSR_ADDR_W-1:0] == LED_ADR)
					check_value({name, " pins"}, 32'(exp[`GPIO_OUT_W-1:0]), 32'(led_o));
			end
			OP_POLL: poll_until(name, adr, dat, exp);
			OP_BUTTONS: begin
				btn_i = dat[`GPIO_IN_W-1:0];
				next_cycle();
			end
			OP_WAIT_RESET: wait_reset(name);
			OP_IRQ: check_value(name, exp, 32'(irq_o));
			default: begin
				assert (1'b0) else begin
					$display("Case %0d has an unknown opcode %h", n, op);
					proto_errs++;
				end
			end
		endcase
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial begin
		trigger_reset = 1'b1;
		btn_i = '0;
		csr_stb_i = 1'b0;
		csr_we_i = 1'b0;
		csr_adr_i = '0;
		csr_dat_i = '0;
		value_errs = 0;
		proto_errs = 0;
		cycles = 0;
		rng_state = 32'd60037;
		last_rand = '0;
		for (int i = 0; i < 4 * MAX_CASES; i++)
			cases[i] = '0;
		$readmemh("soc_cases.txt", cases);
		num_cases = 0;
		while (num_cases < MAX_CASES && cases[4*num_cases] != OP_END)
			num_cases++;
		cycle_limit = 8 * (`RST_HOLD_CYCLES + num_cases * 40);
		assert (num_cases > 0) else begin
			$display("No cases were loaded from the case file");
			proto_errs++;
		end

		repeat (8) @(posedge sys_clk);
		#2;
		trigger_reset = 1'b0;
		check_reset_release();

		for (int i = 0; i < num_cases; i++)
			run_case(i);

		$display("Errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== soc_cases.txt ====
// op addr data expect; op 01 write, 02 read, 03 poll (data is the mask), 04 buttons,
// 05 wait for reset, 06 irq line level, 11 write random, 12 read back random, 00 end
01 00000401 00000003 00000000 // LED on
02 00000401 00000000 00000003
11 00000403 00000000 00000000 // timer compare pattern
12 00000403 00000000 00000000
02 00000405 00000000 53595343 // system id
02 00000000 00000000 00000000 // bank 0
02 000002A7 00000000 00000000
02 00000C00 00000000 00000000 // bank 3
02 00000FFF 00000000 00000000
01 00000801 00000000 0000000C // mask gpio and timer
01 00000801 0000000C 00000000
04 00000000 00000001 00000000 // one button pressed
03 00000800 00000004 00000004
06 00000000 00000000 00000001
03 00000400 00000007 00000001
01 00000800 00000004 00000000 // clear gpio pending
02 00000800 00000000 00000000
06 00000000 00000000 00000000
01 00000403 00000020 00000000 // timer run
01 00000402 00000001 00000000
03 00000800 00000008 00000008
02 00000402 00000000 00000000
01 00000406 00000001 00000000 // hard reset
05 00000000 00000000 00000000
02 00000401 00000000 00000000
01 00000401 00000002 00000000
04 00000000 00000007 00000000 // all buttons
04 00000000 00000000 00000000
05 00000000 00000000 00000000
02 00000401 00000000 00000000
00 00000000 00000000 00000000

// ==== project.f ====
+incdir+.
soc_pkg.sv
reset_gen.sv
csr_bus.sv
sysctl.sv
irq_collect.sv
soc_top.sv
soc_asserts.sv
tb_soc.sv

// ==== Makefile ====
all: run

obj_dir/Vtb_soc: project.f soc_settings.svh soc_pkg.sv reset_gen.sv csr_bus.sv sysctl.sv \
		irq_collect.sv soc_top.sv soc_asserts.sv tb_soc.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f project.f

run: obj_dir/Vtb_soc
	./obj_dir/Vtb_soc > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing --assert -Wall --top-module tb_soc -f project.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
